// ==== prf_pkg.sv ====
package prf_pkg;

   localparam int IPRF_NUM_WRITES = 2;   // Write ports into the integer PRF.
   localparam int PRF_ID_W        = 6;
   localparam int RV_XLEN         = 32;

   typedef logic [PRF_ID_W-1:0] t_prf_id;
   typedef logic [RV_XLEN-1:0]  t_rv_reg_data;

   // One write into the physical register file.
   typedef struct packed {
      t_prf_id      pdst;
      t_rv_reg_data data;
   } t_prf_wr_pkt;

endpackage

// ==== prf_wb_if.sv ====
interface prf_wb_if (
   input logic clk
);
   import prf_pkg::*;

   logic        wr_en  [IPRF_NUM_WRITES-1:0];   // Single-cycle write strobes.
   t_prf_wr_pkt wr_pkt [IPRF_NUM_WRITES-1:0];

   // Write side, driven from the top level.
   modport src (
      output wr_en,
      output wr_pkt
   );

   // Snooping side, one per tracker.
   modport mon (
      input clk,
      input wr_en,
      input wr_pkt
   );

endinterface

// ==== rs_age_ctr.sv ====
module rs_age_ctr #(
   parameter int RS_NUM_ENTRIES = rs_pkg::RS_DEF_NUM_ENTRIES
) (
   input  logic                      clk,
   input  logic                      reset,

   input  logic                      alloc,
   input  logic [RS_NUM_ENTRIES-1:0] busy,
   input  logic [RS_NUM_ENTRIES-1:0] req,
   input  logic                      issue_stall,

   output logic [RS_NUM_ENTRIES-1:0] alloc_entry,
   output logic [RS_NUM_ENTRIES-1:0] grant,
   output logic                      full
);
   localparam int AW = (RS_NUM_ENTRIES > 1) ? $clog2(RS_NUM_ENTRIES) : 1;

   logic [AW-1:0] age [RS_NUM_ENTRIES];   // Busy entries older than this one.
   logic [AW-1:0] grant_age;
   logic [AW-1:0] keep_cnt;
   logic          found;

   assign full = &busy;

   // Lowest free entry.
   always_comb begin
      alloc_entry = '0;
      found       = 1'b0;
      for (int i = 0; i < RS_NUM_ENTRIES; i++) begin
         if (!busy[i] && !found) begin
            alloc_entry[i] = 1'b1;
            found          = 1'b1;
         end
      end
   end

   // Oldest requester has the fewest older entries.
   always_comb begin
      grant = '0;
      for (int i = 0; i < RS_NUM_ENTRIES; i++) begin
         grant[i] = req[i] & ~issue_stall;
         for (int j = 0; j < RS_NUM_ENTRIES; j++) begin
            if (j != i && req[j] && age[j] < age[i]) grant[i] = 1'b0;
         end
      end
   end

   always_comb begin
      grant_age = '0;
      keep_cnt  = '0;
      for (int i = 0; i < RS_NUM_ENTRIES; i++) begin
         if (grant[i]) grant_age = age[i];
         keep_cnt = keep_cnt + AW'(busy[i] & ~grant[i]);   // Still busy after this edge.
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < RS_NUM_ENTRIES; i++) age[i] <= '0;
      end else begin
         for (int i = 0; i < RS_NUM_ENTRIES; i++) begin
            if (alloc && alloc_entry[i]) begin
               age[i] <= keep_cnt;
            end else if (busy[i] && |grant && age[i] > grant_age) begin
               age[i] <= age[i] - 1'b1;   // Lost one older entry.
            end
         end
      end
   end

   // Holds only while the counts of busy entries stay distinct.
   a_grant_onehot: assert property (
      @(posedge clk) disable iff (reset) $onehot0(grant)
   );

endmodule

// ==== rs_alloc_if.sv ====
interface rs_alloc_if #(
   parameter int RS_NUM_ENTRIES = rs_pkg::RS_DEF_NUM_ENTRIES
);
   import rs_pkg::*;

   logic                      alloc;         // Strobe.
   logic [RS_NUM_ENTRIES-1:0] alloc_entry;   // One-hot target entry.
   t_rs_alloc_pkt             pkt;

   modport drv (
      output alloc,
      output alloc_entry,
      output pkt
   );

   // Every entry sees the whole bus and picks its own select bit.
   modport ent (
      input alloc,
      input alloc_entry,
      input pkt
   );

endinterface

// ==== rs_entry_ctl.sv ====
module rs_entry_ctl #(
   parameter int ENTRY_IDX = 0
) (
   input  logic                  clk,
   input  logic                  reset,

   rs_alloc_if.ent               al,
   prf_wb_if.mon                 wb,

   input  logic                  grant,
   output logic                  busy,
   output logic                  req,
   output rs_pkg::t_rs_issue_pkt issue_pkt
);
   import prf_pkg::*;
   import rs_pkg::*;

   typedef enum logic [1:0] {
      FREE,
      WAIT_SRC,
      RDY
   } t_state;

   t_state       state;
   t_state       state_nxt;
   logic         e_alloc;
   t_rs_op       op;
   t_prf_id      pdst;
   logic         src0_ready;
   logic         src1_ready;
   logic         src0_from_prf;
   logic         src1_from_prf;
   t_rv_reg_data src0_data;
   t_rv_reg_data src1_data;
   logic         src_ready;

   assign e_alloc = al.alloc & al.alloc_entry[ENTRY_IDX];

   always_ff @(posedge clk) begin
      if (e_alloc) begin
         op   <= al.pkt.op;
         pdst <= al.pkt.pdst;
      end
   end

   rs_reg_trk u_src0 (
      .clk            (clk),
      .reset          (reset),
      .e_alloc        (e_alloc),
      .e_alloc_static (al.pkt.src0),
      .e_static       (),
      .wb             (wb),
      .ready          (src0_ready),
      .from_prf       (src0_from_prf),
      .src_data       (src0_data)
   );

   rs_reg_trk u_src1 (
      .clk            (clk),
      .reset          (reset),
      .e_alloc        (e_alloc),
      .e_alloc_static (al.pkt.src1),
      .e_static       (),
      .wb             (wb),
      .ready          (src1_ready),
      .from_prf       (src1_from_prf),
      .src_data       (src1_data)
   );

   assign src_ready = src0_ready & src1_ready;

   always_comb begin
      state_nxt = state;
      unique case (state)
         FREE:     if (e_alloc) state_nxt = WAIT_SRC;
         WAIT_SRC: begin
            if (grant)          state_nxt = FREE;
            else if (src_ready) state_nxt = RDY;
         end
         RDY:      if (grant) state_nxt = FREE;
         default:  state_nxt = FREE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) state <= FREE;
      else       state <= state_nxt;
   end

   assign busy = (state != FREE);
   assign req  = (state == RDY) | ((state == WAIT_SRC) & src_ready);   // No wait after wakeup.

   always_comb begin
      issue_pkt               = '0;
      issue_pkt.op            = op;
      issue_pkt.pdst          = pdst;
      issue_pkt.src0.from_prf = src0_from_prf;
      issue_pkt.src0.data     = src0_data;
      issue_pkt.src1.from_prf = src1_from_prf;
      issue_pkt.src1.data     = src1_data;
   end

   // The age counter may only pick an entry that is asking.
   a_grant_on_req: assert property (
      @(posedge clk) disable iff (reset) grant |-> req
   );

endmodule

// ==== rs_issue_sel.sv ====
module rs_issue_sel #(
   parameter int RS_NUM_ENTRIES = rs_pkg::RS_DEF_NUM_ENTRIES
) (
   input  logic                      clk,
   input  logic                      reset,

   input  logic [RS_NUM_ENTRIES-1:0] grant,
   input  logic                      issue_stall,
   input  rs_pkg::t_rs_issue_pkt     entry_pkt [RS_NUM_ENTRIES],

   output logic                      issue_valid,
   output rs_pkg::t_rs_issue_pkt     issue_pkt
);
   import rs_pkg::*;

   t_rs_issue_pkt sel_pkt;
   logic          any_grant;

   assign any_grant = |grant;

   // Grant is one-hot, so an AND-OR mux is enough.
   always_comb begin
      sel_pkt = '0;
      for (int i = 0; i < RS_NUM_ENTRIES; i++) begin
         sel_pkt = sel_pkt | (entry_pkt[i] & {$bits(t_rs_issue_pkt){grant[i]}});
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         issue_valid <= 1'b0;
      end else if (!issue_stall) begin
         issue_valid <= any_grant;   // Held while stalled.
      end
   end

   always_ff @(posedge clk) begin
      if (!issue_stall && any_grant) issue_pkt <= sel_pkt;
   end

endmodule

// ==== rs_pkg.sv ====
package rs_pkg;

   localparam int RS_DEF_NUM_ENTRIES = 4;   // Default depth of the station.

   typedef logic [5:0] t_rs_op;

   typedef struct packed {
      logic       is_imm;
      logic [4:0] areg;      // Architectural register number.
   } t_uopnd_descr;

   // What a tracker keeps about its source for the life of the entry.
   typedef struct packed {
      logic              psrc_pend;
      prf_pkg::t_prf_id  psrc;
      t_uopnd_descr      descr;
   } t_rs_reg_trk_static;

   typedef struct packed {
      t_rs_op             op;
      t_rs_reg_trk_static src0;
      t_rs_reg_trk_static src1;
      prf_pkg::t_prf_id   pdst;
   } t_rs_alloc_pkt;

   typedef struct packed {
      logic                  from_prf;   // Read the PRF at issue, data is unused.
      prf_pkg::t_rv_reg_data data;
   } t_rs_issue_src;

   typedef struct packed {
      t_rs_op           op;
      prf_pkg::t_prf_id pdst;
      t_rs_issue_src    src0;
      t_rs_issue_src    src1;
   } t_rs_issue_pkt;

endpackage

// ==== rs_reg_trk.sv ====
module rs_reg_trk (
   input  logic                       clk,
   input  logic                       reset,

   input  logic                       e_alloc,
   input  rs_pkg::t_rs_reg_trk_static e_alloc_static,
   output rs_pkg::t_rs_reg_trk_static e_static,

   prf_wb_if.mon                      wb,

   output logic                       ready,
   output logic                       from_prf,
   output prf_pkg::t_rv_reg_data      src_data
);
   import prf_pkg::*;
   import rs_pkg::*;

   typedef enum logic {
      SRC_PDG_RSLT,
      SRC_READY
   } t_fsm;

   t_fsm                       fsm;
   t_fsm                       fsm_nxt;
   t_rs_reg_trk_static         e_static_nxt;
   logic [IPRF_NUM_WRITES-1:0] wb_match;
   logic                       wb_match_any;
   logic                       waiting;

   assign ready    = (fsm == SRC_READY);
   assign from_prf = ~e_static.psrc_pend;

   // Compare against the incoming static on the allocation cycle.
   assign e_static_nxt = e_alloc ? e_alloc_static : e_static;

   always_ff @(posedge clk) begin
      if (e_alloc) e_static <= e_alloc_static;
   end

   for (genvar p = 0; p < IPRF_NUM_WRITES; p++) begin : g_wb_match
      assign wb_match[p] = wb.wr_en[p] & (wb.wr_pkt[p].pdst == e_static_nxt.psrc);
   end
   assign wb_match_any = |wb_match;

   assign waiting = e_alloc ? e_alloc_static.psrc_pend : (fsm == SRC_PDG_RSLT);

   always_ff @(posedge clk) begin
      if (wb_match_any && waiting) src_data <= wb.wr_pkt[0].data;   // Port 0 data only.
   end

   always_comb begin
      fsm_nxt = fsm;
      if (e_alloc) begin
         fsm_nxt = (e_alloc_static.psrc_pend && !wb_match_any) ? SRC_PDG_RSLT : SRC_READY;
      end else begin
         unique case (fsm)
            SRC_READY:    fsm_nxt = SRC_READY;
            SRC_PDG_RSLT: if (wb_match_any) fsm_nxt = SRC_READY;
            default:      fsm_nxt = SRC_READY;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) fsm <= SRC_READY;
      else       fsm <= fsm_nxt;
   end

   // Only a source that was pending at allocation can still be waiting.
   a_pdg_has_pend: assert property (
      @(posedge wb.clk) disable iff (reset) (fsm == SRC_PDG_RSLT) |-> e_static.psrc_pend
   );

endmodule

// ==== rs_top.sv ====
module rs_top #(
   parameter int RS_NUM_ENTRIES = rs_pkg::RS_DEF_NUM_ENTRIES
) (
   input  logic                  clk,
   input  logic                  reset,

   input  logic                  alloc,
   input  rs_pkg::t_rs_alloc_pkt alloc_pkt,
   output logic                  rs_full,

   input  logic                  iprf_wr_en  [prf_pkg::IPRF_NUM_WRITES-1:0],
   input  prf_pkg::t_prf_wr_pkt  iprf_wr_pkt [prf_pkg::IPRF_NUM_WRITES-1:0],

   input  logic                  issue_stall,
   output logic                  issue_valid,
   output rs_pkg::t_rs_issue_pkt issue_pkt
);
   import rs_pkg::*;

   logic [RS_NUM_ENTRIES-1:0] ent_busy;
   logic [RS_NUM_ENTRIES-1:0] ent_req;
   logic [RS_NUM_ENTRIES-1:0] ent_grant;
   logic [RS_NUM_ENTRIES-1:0] free_entry;
   t_rs_issue_pkt             entry_pkt [RS_NUM_ENTRIES];

   prf_wb_if wb_if (
      .clk (clk)
   );

   rs_alloc_if #(
      .RS_NUM_ENTRIES (RS_NUM_ENTRIES)
   ) al_if ();

   assign wb_if.wr_en       = iprf_wr_en;
   assign wb_if.wr_pkt      = iprf_wr_pkt;
   assign al_if.alloc       = alloc;
   assign al_if.alloc_entry = free_entry;
   assign al_if.pkt         = alloc_pkt;

   for (genvar e = 0; e < RS_NUM_ENTRIES; e++) begin : g_ent
      rs_entry_ctl #(
         .ENTRY_IDX (e)
      ) u_ent (
         .clk       (clk),
         .reset     (reset),
         .al        (al_if.ent),
         .wb        (wb_if.mon),
         .grant     (ent_grant[e]),
         .busy      (ent_busy[e]),
         .req       (ent_req[e]),
         .issue_pkt (entry_pkt[e])
      );
   end

   rs_age_ctr #(
      .RS_NUM_ENTRIES (RS_NUM_ENTRIES)
   ) u_age (
      .clk         (clk),
      .reset       (reset),
      .alloc       (alloc),
      .busy        (ent_busy),
      .req         (ent_req),
      .issue_stall (issue_stall),
      .alloc_entry (free_entry),
      .grant       (ent_grant),
      .full        (rs_full)
   );

   rs_issue_sel #(
      .RS_NUM_ENTRIES (RS_NUM_ENTRIES)
   ) u_issue (
      .clk         (clk),
      .reset       (reset),
      .grant       (ent_grant),
      .issue_stall (issue_stall),
      .entry_pkt   (entry_pkt),
      .issue_valid (issue_valid),
      .issue_pkt   (issue_pkt)
   );

endmodule

// ==== tb.f ====
prf_pkg.sv
rs_pkg.sv
prf_wb_if.sv
rs_alloc_if.sv
rs_reg_trk.sv
rs_entry_ctl.sv
rs_age_ctr.sv
rs_issue_sel.sv
rs_top.sv
tb_rs_top.sv

// ==== tb_rs_top.sv ====
module tb_rs_top;
   timeunit 1ns;
   timeprecision 100ps;

   import prf_pkg::*;
   import rs_pkg::*;

   typedef struct {
      t_rs_issue_pkt pkt;
      logic          pend0;
      logic          pend1;
      t_prf_id       psrc0;
      t_prf_id       psrc1;
   } t_model;

   logic          clk;
   logic          reset;
   logic          alloc;
   t_rs_alloc_pkt alloc_pkt;
   logic          rs_full;
   logic          iprf_wr_en  [IPRF_NUM_WRITES-1:0];
   t_prf_wr_pkt   iprf_wr_pkt [IPRF_NUM_WRITES-1:0];
   logic          issue_stall;
   logic          issue_valid;
   t_rs_issue_pkt issue_pkt;

   t_model        model_q [$];
   t_rs_issue_pkt exp_pkt;
   logic          exp_found;
   int            exp_idx;
   logic          accept;
   logic          quick;        // Alloc cycle of a micro-op that must issue two cycles later.
   t_prf_id       quick_pdst;
   t_prf_id       next_pdst;
   int            errors;
   int            issued;

   rs_top #(
      .RS_NUM_ENTRIES (4)
   ) dut (
      .clk         (clk),
      .reset       (reset),
      .alloc       (alloc),
      .alloc_pkt   (alloc_pkt),
      .rs_full     (rs_full),
      .iprf_wr_en  (iprf_wr_en),
      .iprf_wr_pkt (iprf_wr_pkt),
      .issue_stall (issue_stall),
      .issue_valid (issue_valid),
      .issue_pkt   (issue_pkt)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   assign accept = issue_valid & ~issue_stall;

   task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] got);
      errors++;
      $display("error %0t %s expected %h actual %h", $time, name, exp, got);
   endtask

   task automatic report_text(input string what);
      errors++;
      $display("%0t %s", $time, what);
   endtask

   // Oldest model entry with both sources available.
   function automatic int first_ready();
      for (int i = 0; i < model_q.size(); i++) begin
         if (!model_q[i].pend0 && !model_q[i].pend1) return i;
      end
      return -1;
   endfunction

   always @(negedge clk) begin
      #5;
      exp_idx   = first_ready();
      exp_found = (exp_idx >= 0);
      exp_pkt   = exp_found ? model_q[exp_idx].pkt : '0;
   end

   always @(posedge clk) begin
      if (!reset && accept && exp_found) begin
         model_q.delete(exp_idx);
         issued++;
      end
   end

   a_reset_out: assert property (@(posedge clk) $fell(reset) |-> !issue_valid && !rs_full)
      else report_text("issue_valid or rs_full is high right after reset");
   a_known: assert property (@(posedge clk) disable iff (reset) accept |-> exp_found)
      else report_text("issue of a micro-op that the model does not hold as ready");
   a_op: assert property (@(posedge clk) disable iff (reset) accept |-> issue_pkt.op == exp_pkt.op)
      else report_value("issue_pkt.op", $sampled(exp_pkt.op), $sampled(issue_pkt.op));
   a_pdst: assert property (
      @(posedge clk) disable iff (reset) accept |-> issue_pkt.pdst == exp_pkt.pdst
   ) else report_value("issue_pkt.pdst", $sampled(exp_pkt.pdst), $sampled(issue_pkt.pdst));
   a_prf0: assert property (
      @(posedge clk) disable iff (reset) accept |-> issue_pkt.src0.from_prf == exp_pkt.src0.from_prf
   ) else report_value("issue_pkt.src0.from_prf", $sampled(exp_pkt.src0.from_prf),
                       $sampled(issue_pkt.src0.from_prf));
   a_prf1: assert property (
      @(posedge clk) disable iff (reset) accept |-> issue_pkt.src1.from_prf == exp_pkt.src1.from_prf
   ) else report_value("issue_pkt.src1.from_prf", $sampled(exp_pkt.src1.from_prf),
                       $sampled(issue_pkt.src1.from_prf));
   a_data0: assert property (
      @(posedge clk) disable iff (reset)
      accept && !exp_pkt.src0.from_prf |-> issue_pkt.src0.data == exp_pkt.src0.data
   ) else report_value("issue_pkt.src0.data", $sampled(exp_pkt.src0.data),
                       $sampled(issue_pkt.src0.data));
   a_data1: assert property (
      @(posedge clk) disable iff (reset)
      accept && !exp_pkt.src1.from_prf |-> issue_pkt.src1.data == exp_pkt.src1.data
   ) else report_value("issue_pkt.src1.data", $sampled(exp_pkt.src1.data),
                       $sampled(issue_pkt.src1.data));
   a_quick: assert property (
      @(posedge clk) disable iff (reset) quick |-> ##2 (issue_valid && issue_pkt.pdst == quick_pdst)
   ) else report_text("ready micro-op did not issue two cycles after allocation");

   task automatic tick();
      @(negedge clk);
   endtask

   // Called on a falling edge; a wake_now write on port 0 hits source 0 in the alloc cycle.
   task automatic alloc_uop(input logic pend0, input logic pend1, input t_prf_id ps0,
                            input t_prf_id ps1, input logic wake_now, input logic is_quick);
      t_rs_alloc_pkt pkt;
      t_model        m;
      t_rv_reg_data  d;
      pkt.op          = 6'($urandom);
      pkt.pdst        = next_pdst;
      pkt.src0        = '{psrc_pend: pend0, psrc: ps0, descr: 6'($urandom)};
      pkt.src1        = '{psrc_pend: pend1, psrc: ps1, descr: 6'($urandom)};
      next_pdst++;
      m.pkt               = '0;
      m.pkt.op            = pkt.op;
      m.pkt.pdst          = pkt.pdst;
      m.pkt.src0.from_prf = !pend0;
      m.pkt.src1.from_prf = !pend1;
      m.pend0             = pend0;
      m.pend1             = pend1;
      m.psrc0             = ps0;
      m.psrc1             = ps1;
      if (wake_now) begin
         d                  = $urandom;
         iprf_wr_en[0]      = 1'b1;
         iprf_wr_pkt[0]     = '{pdst: ps0, data: d};
         m.pend0            = 1'b0;
         m.pkt.src0.data    = d;
      end
      alloc     = 1'b1;
      alloc_pkt = pkt;
      quick     = is_quick;
      if (is_quick) quick_pdst = pkt.pdst;
      model_q.push_back(m);
      tick();
      alloc         = 1'b0;
      quick         = 1'b0;
      iprf_wr_en[0] = 1'b0;
   endtask

   // Trackers capture port 0 data whichever port matched.
   task automatic write_port(input int port, input t_prf_id pdst, input t_rv_reg_data d,
                             input t_rv_reg_data d0);
      t_rv_reg_data cap;
      iprf_wr_en[port]  = 1'b1;
      iprf_wr_pkt[port] = '{pdst: pdst, data: d};
      if (port != 0) iprf_wr_pkt[0] = '{pdst: 6'd63, data: d0};
      cap = (port == 0) ? d : d0;
      foreach (model_q[i]) begin
         if (model_q[i].pend0 && model_q[i].psrc0 == pdst) begin
            model_q[i].pend0         = 1'b0;
            model_q[i].pkt.src0.data = cap;
         end
         if (model_q[i].pend1 && model_q[i].psrc1 == pdst) begin
            model_q[i].pend1         = 1'b0;
            model_q[i].pkt.src1.data = cap;
         end
      end
      tick();
      iprf_wr_en[port] = 1'b0;
   endtask

   task automatic drain(input string what, input logic rand_stall);
      int cycles;
      cycles = 0;
      while (model_q.size() != 0 && cycles < 60) begin
         if (rand_stall) issue_stall = $urandom_range(1, 0);
         tick();
         cycles++;
      end
      issue_stall = 1'b0;
      if (model_q.size() != 0) report_text({"timeout waiting for issue: ", what});
      repeat (3) tick();
   endtask

   task automatic idle(input int n);
      repeat (n) tick();
   endtask

   initial begin
      int cycles;
      void'($urandom(55));
      reset       = 1'b1;
      alloc       = 1'b0;
      alloc_pkt   = '0;
      issue_stall = 1'b0;
      quick       = 1'b0;
      quick_pdst  = '0;
      next_pdst   = '0;
      errors      = 0;
      issued      = 0;
      exp_found   = 1'b0;
      exp_idx     = -1;
      exp_pkt     = '0;
      for (int p = 0; p < IPRF_NUM_WRITES; p++) begin
         iprf_wr_en[p]  = 1'b0;
         iprf_wr_pkt[p] = '0;
      end
      repeat (16) @(negedge clk);
      reset = 1'b0;
      idle(2);

      alloc_uop(1'b0, 1'b0, 6'd1, 6'd2, 1'b0, 1'b1);
      drain("no pending source", 1'b0);

      alloc_uop(1'b1, 1'b0, 6'd10, 6'd3, 1'b0, 1'b0);
      idle(3);
      write_port(0, 6'd10, $urandom, 32'h0);
      drain("source 0 woken on port 0", 1'b0);
      alloc_uop(1'b0, 1'b1, 6'd4, 6'd11, 1'b0, 1'b0);
      idle(2);
      write_port(1, 6'd11, $urandom, $urandom);
      drain("source 1 woken on port 1", 1'b0);

      alloc_uop(1'b1, 1'b0, 6'd20, 6'd5, 1'b1, 1'b1);
      drain("woken in the alloc cycle", 1'b0);

      issue_stall = 1'b1;
      for (int i = 0; i < 3; i++) alloc_uop(1'b0, 1'b0, 6'd6, 6'd7, 1'b0, 1'b0);
      idle(4);
      issue_stall = 1'b0;
      drain("ready together", 1'b0);
      for (int i = 0; i < 4; i++) alloc_uop(1'b0, 1'b0, 6'd8, 6'd9, 1'b0, 1'b0);
      drain("random stall", 1'b1);

      issue_stall = 1'b1;
      for (int i = 0; i < 4; i++) begin
         a_room: assert (!rs_full) else report_text("rs_full is high with a free entry");
         alloc_uop(1'b0, 1'b0, 6'd12, 6'd13, 1'b0, 1'b0);
      end
      a_full: assert (rs_full) else report_text("rs_full is low with every entry busy");
      issue_stall = 1'b0;
      cycles = 0;
      while (!issue_valid && cycles < 20) begin
         tick();
         cycles++;
      end
      if (!issue_valid) report_text("timeout waiting for the first issue of a full station");
      a_not_full: assert (!rs_full) else report_text("rs_full stayed high after an issue");
      drain("full station", 1'b0);

      $display("issued %0d micro-ops, %0d left in model, %0d errors",
               issued, model_q.size(), errors);
      if (errors == 0 && model_q.size() == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule
